/* source/rv32i_pkg.sv */
`default_nettype none

package rv32i_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int BYTE_LANES = 4;
    localparam int PC_STEP    = 4;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_idx_t;
    typedef logic [BYTE_LANES-1:0] byte_en_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_XOR,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // Branch funct3 encodings, 3'b010 and 3'b011 are unused
    typedef enum logic [2:0] {
        CMP_BEQ  = 3'b000,
        CMP_BNE  = 3'b001,
        CMP_BLT  = 3'b100,
        CMP_BGE  = 3'b101,
        CMP_BLTU = 3'b110,
        CMP_BGEU = 3'b111
    } cmp_op_e;

    typedef enum logic [2:0] {
        OP_ALU,
        OP_SET,
        OP_BRANCH,
        OP_JAL,
        OP_JALR,
        OP_LOAD,
        OP_STORE,
        OP_LUI
    } op_kind_e;

    // Load and store funct3 widths
    typedef enum logic [2:0] {
        MEM_B  = 3'b000,
        MEM_H  = 3'b001,
        MEM_W  = 3'b010,
        MEM_BU = 3'b100,
        MEM_HU = 3'b101
    } mem_size_e;

    typedef enum logic {
        SRC_A_RS1,
        SRC_A_PC
    } src_a_e;

    typedef enum logic {
        SRC_B_RS2,
        SRC_B_IMM
    } src_b_e;

    typedef struct packed {
        op_kind_e  op_kind;
        alu_op_e   alu_op;
        cmp_op_e   cmp_op;
        mem_size_e mem_size;
        src_a_e    src_a;
        src_b_e    src_b;
        logic      trap;     // Illegal compare seen in EX
    } ctrl_t;

    typedef struct packed {
        logic     valid;
        ctrl_t    ctrl;
        word_t    pc;
        word_t    rs1;
        word_t    rs2;
        word_t    imm;
        reg_idx_t rd;
    } issue_t;

    typedef struct packed {
        logic     valid;
        ctrl_t    ctrl;
        word_t    alu_result;
        logic     cmp_flag;
        word_t    store_data;
        word_t    link;
        reg_idx_t rd;
    } ex_mem_t;

    typedef struct packed {
        logic     read;
        logic     write;
        word_t    addr;
        word_t    wdata;
        byte_en_t byte_en;
    } dmem_req_t;

    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

    typedef struct packed {
        logic     valid;
        logic     trap;
        reg_idx_t rd;
        word_t    data;
    } wb_t;

endpackage

`default_nettype wire

/* source/exec_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_alu
    import rv32i_pkg::*;
(
    input  wire alu_op_e i_op,
    input  wire word_t   i_a,
    input  wire word_t   i_b,
    output word_t        o_result
);

    logic [4:0] shamt;

    // Only the low five bits of B count for shifts
    assign shamt = i_b[4:0];

    always_comb begin
        case (i_op)
            ALU_ADD: begin
                o_result = i_a + i_b;
            end
            ALU_SUB: begin
                o_result = i_a - i_b;
            end
            ALU_SLL: begin
                o_result = i_a << shamt;
            end
            ALU_SRL: begin
                o_result = i_a >> shamt;
            end
            ALU_SRA: begin
                o_result = word_t'($signed(i_a) >>> shamt);
            end
            ALU_XOR: begin
                o_result = i_a ^ i_b;
            end
            ALU_OR: begin
                o_result = i_a | i_b;
            end
            default: begin
                o_result = i_a & i_b;
            end
        endcase
    end

endmodule

`default_nettype wire

/* source/branch_cmp.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_cmp
    import rv32i_pkg::*;
(
    input  wire cmp_op_e i_op,
    input  wire word_t   i_a,
    input  wire word_t   i_b,
    output logic         o_taken,
    output logic         o_illegal
);

    logic lt_signed;
    logic lt_unsigned;
    logic equal;

    assign lt_signed   = $signed(i_a) < $signed(i_b);
    assign lt_unsigned = i_a < i_b;
    assign equal       = i_a == i_b;

    // blt and bltu double as slt and sltu
    always_comb begin
        o_taken   = 1'b0;
        o_illegal = 1'b0;
        case (i_op)
            CMP_BEQ:  o_taken = equal;
            CMP_BNE:  o_taken = !equal;
            CMP_BLT:  o_taken = lt_signed;
            CMP_BGE:  o_taken = !lt_signed;
            CMP_BLTU: o_taken = lt_unsigned;
            CMP_BGEU: o_taken = !lt_unsigned;
            default:  o_illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

/* source/ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_stage
    import rv32i_pkg::*;
(
    input  wire         i_clk,
    input  wire         i_rst_n,
    input  wire issue_t i_issue,
    input  wire         i_hold,
    output logic        o_issue_ready,
    output ex_mem_t     o_ex_mem,
    output redirect_t   o_redirect
);

    logic    accept;
    word_t   alu_a;
    word_t   alu_b;
    word_t   cmp_b;
    word_t   alu_result;
    logic    cmp_taken;
    logic    cmp_illegal;
    logic    uses_cmp;
    logic    redirect_taken;
    word_t   redirect_target;
    ex_mem_t ex_mem_next;

    // MEM back-pressure stalls the issue side
    assign o_issue_ready = !i_hold;
    assign accept        = i_issue.valid && o_issue_ready;

    assign alu_a = (i_issue.ctrl.src_a == SRC_A_PC) ? i_issue.pc : i_issue.rs1;
    assign alu_b = (i_issue.ctrl.src_b == SRC_B_IMM) ? i_issue.imm : i_issue.rs2;

    // Branches keep the ALU busy as the target adder, so rs2 goes straight to the comparator
    assign cmp_b = (i_issue.ctrl.op_kind == OP_BRANCH || i_issue.ctrl.src_b == SRC_B_RS2) ?
                   i_issue.rs2 : i_issue.imm;

    exec_alu alu_inst (
        .i_op     (i_issue.ctrl.alu_op),
        .i_a      (alu_a),
        .i_b      (alu_b),
        .o_result (alu_result)
    );

    branch_cmp cmp_inst (
        .i_op      (i_issue.ctrl.cmp_op),
        .i_a       (i_issue.rs1),
        .i_b       (cmp_b),
        .o_taken   (cmp_taken),
        .o_illegal (cmp_illegal)
    );

    assign uses_cmp = (i_issue.ctrl.op_kind == OP_BRANCH) || (i_issue.ctrl.op_kind == OP_SET);

    always_comb begin
        redirect_taken = 1'b0;
        case (i_issue.ctrl.op_kind)
            OP_BRANCH: redirect_taken = cmp_taken && !cmp_illegal;
            OP_JAL:    redirect_taken = 1'b1;
            OP_JALR:   redirect_taken = 1'b1;
            default:   redirect_taken = 1'b0;
        endcase
    end

    // jalr target drops bit 0
    assign redirect_target = {alu_result[XLEN-1:1],
                              alu_result[0] && (i_issue.ctrl.op_kind != OP_JALR)};

    always_comb begin
        ex_mem_next            = '0;
        ex_mem_next.valid      = i_issue.valid;
        ex_mem_next.ctrl       = i_issue.ctrl;
        ex_mem_next.ctrl.trap  = i_issue.ctrl.trap || (uses_cmp && cmp_illegal);
        ex_mem_next.alu_result = alu_result;
        ex_mem_next.cmp_flag   = cmp_taken;
        ex_mem_next.store_data = i_issue.rs2;
        ex_mem_next.link       = i_issue.pc + word_t'(PC_STEP);
        ex_mem_next.rd         = i_issue.rd;
    end

    // EX/MEM register, frozen while MEM holds
    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_ex_mem <= ex_mem_next;
        end
        if (!i_rst_n) begin
            o_ex_mem.valid <= 1'b0;
        end else if (!i_hold) begin
            o_ex_mem.valid <= accept;
        end
    end

    // One-cycle redirect pulse per accepted control transfer
    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_redirect.target <= redirect_target;
        end
        if (!i_rst_n) begin
            o_redirect.valid <= 1'b0;
        end else begin
            o_redirect.valid <= accept && redirect_taken;
        end
    end

endmodule

`default_nettype wire

/* source/mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage
    import rv32i_pkg::*;
(
    input  wire          i_clk,
    input  wire          i_rst_n,
    input  wire ex_mem_t i_ex_mem,
    input  wire          i_dmem_resp,
    input  wire word_t   i_dmem_rdata,
    output dmem_req_t    o_dmem,
    output logic         o_hold,
    output wb_t          o_wb
);

    logic       is_load;
    logic       is_store;
    logic [1:0] offset;
    logic       size_ok;
    logic       misaligned;
    logic       trap;
    logic       req_active;
    byte_en_t   byte_en;
    word_t      lane;
    word_t      load_data;
    word_t      wb_data;
    wb_t        wb_next;

    assign is_load  = i_ex_mem.valid && (i_ex_mem.ctrl.op_kind == OP_LOAD);
    assign is_store = i_ex_mem.valid && (i_ex_mem.ctrl.op_kind == OP_STORE);
    assign offset   = i_ex_mem.alu_result[1:0];

    // Size legality and alignment, unsigned widths exist for loads only
    always_comb begin
        size_ok    = 1'b0;
        misaligned = 1'b0;
        byte_en    = '0;
        case (i_ex_mem.ctrl.mem_size)
            MEM_B, MEM_BU: begin
                size_ok = is_store ? (i_ex_mem.ctrl.mem_size == MEM_B) : 1'b1;
                byte_en = byte_en_t'(1) << offset;
            end
            MEM_H, MEM_HU: begin
                size_ok    = is_store ? (i_ex_mem.ctrl.mem_size == MEM_H) : 1'b1;
                misaligned = offset[0];
                byte_en    = byte_en_t'(3) << offset;
            end
            MEM_W: begin
                size_ok    = 1'b1;
                misaligned = offset != 2'b00;
                byte_en    = '1;
            end
            default: begin
                size_ok = 1'b0;
            end
        endcase
    end

    assign trap = i_ex_mem.valid &&
                  (i_ex_mem.ctrl.trap || ((is_load || is_store) && (misaligned || !size_ok)));

    assign req_active = (is_load || is_store) && !trap;

    // Request stays up until the response edge
    always_comb begin
        o_dmem.read    = req_active && is_load;
        o_dmem.write   = req_active && is_store;
        o_dmem.addr    = {i_ex_mem.alu_result[XLEN-1:2], 2'b00};
        o_dmem.wdata   = i_ex_mem.store_data << {offset, 3'b000};
        o_dmem.byte_en = byte_en;
    end

    assign o_hold = req_active && !i_dmem_resp;

    // Move the addressed byte or half down to bit 0
    assign lane = i_dmem_rdata >> {offset, 3'b000};

    always_comb begin
        case (i_ex_mem.ctrl.mem_size)
            MEM_B:   load_data = {{(XLEN-8){lane[7]}}, lane[7:0]};
            MEM_BU:  load_data = {{(XLEN-8){1'b0}}, lane[7:0]};
            MEM_H:   load_data = {{(XLEN-16){lane[15]}}, lane[15:0]};
            MEM_HU:  load_data = {{(XLEN-16){1'b0}}, lane[15:0]};
            default: load_data = i_dmem_rdata;
        endcase
    end

    always_comb begin
        case (i_ex_mem.ctrl.op_kind)
            OP_ALU, OP_LUI: wb_data = i_ex_mem.alu_result;
            OP_SET:         wb_data = word_t'(i_ex_mem.cmp_flag);
            OP_JAL, OP_JALR: wb_data = i_ex_mem.link;
            OP_LOAD:        wb_data = load_data;
            default:        wb_data = '0;
        endcase
        // Trapped instructions write nothing useful
        if (trap) begin
            wb_data = '0;
        end
    end

    always_comb begin
        wb_next.valid = i_ex_mem.valid;
        wb_next.trap  = trap;
        wb_next.rd    = i_ex_mem.rd;
        wb_next.data  = wb_data;
    end

    // Writeback register, nothing retires while the access is outstanding
    always_ff @(posedge i_clk) begin
        if (!o_hold) begin
            o_wb <= wb_next;
        end
        if (!i_rst_n) begin
            o_wb.valid <= 1'b0;
        end else begin
            o_wb.valid <= i_ex_mem.valid && !o_hold;
        end
    end

endmodule

`default_nettype wire

/* source/rv32i_exmem_core.sv */
`timescale 1ns/1ps
`default_nettype none

// LUI runs as rs1 + imm with the issuer supplying rs1 = 0
module rv32i_exmem_core
    import rv32i_pkg::*;
(
    input  wire         i_clk,
    input  wire         i_rst_n,
    input  wire issue_t i_issue,
    output logic        o_issue_ready,
    output redirect_t   o_redirect,
    output dmem_req_t   o_dmem,
    input  wire         i_dmem_resp,
    input  wire word_t  i_dmem_rdata,
    output wb_t         o_wb
);

    ex_mem_t ex_mem;
    logic    mem_hold;

    ex_stage ex_stage_inst (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_issue       (i_issue),
        .i_hold        (mem_hold),
        .o_issue_ready (o_issue_ready),
        .o_ex_mem      (ex_mem),
        .o_redirect    (o_redirect)
    );

    mem_stage mem_stage_inst (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_ex_mem     (ex_mem),
        .i_dmem_resp  (i_dmem_resp),
        .i_dmem_rdata (i_dmem_rdata),
        .o_dmem       (o_dmem),
        .o_hold       (mem_hold),
        .o_wb         (o_wb)
    );

endmodule

`default_nettype wire

/* include/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Reference models for the expected results

function automatic word_t ref_alu(alu_op_e op, word_t a, word_t b);
    case (op)
        ALU_ADD: return a + b;
        ALU_SUB: return a - b;
        ALU_SLL: return a << b[4:0];
        ALU_SRL: return a >> b[4:0];
        ALU_SRA: return word_t'($signed(a) >>> b[4:0]);
        ALU_XOR: return a ^ b;
        ALU_OR:  return a | b;
        default: return a & b;
    endcase
endfunction

function automatic bit ref_cmp(cmp_op_e op, word_t a, word_t b);
    case (op)
        CMP_BEQ:  return a == b;
        CMP_BNE:  return a != b;
        CMP_BLT:  return $signed(a) < $signed(b);
        CMP_BGE:  return $signed(a) >= $signed(b);
        CMP_BLTU: return a < b;
        CMP_BGEU: return a >= b;
        default:  return 1'b0;
    endcase
endfunction

// Writeback value for everything except loads
function automatic word_t ref_result(issue_t ins);
    word_t a;
    word_t b;
    word_t cb;
    a  = (ins.ctrl.src_a == SRC_A_PC) ? ins.pc : ins.rs1;
    b  = (ins.ctrl.src_b == SRC_B_IMM) ? ins.imm : ins.rs2;
    cb = (ins.ctrl.src_b == SRC_B_RS2) ? ins.rs2 : ins.imm;
    case (ins.ctrl.op_kind)
        OP_ALU, OP_LUI:  return ref_alu(ins.ctrl.alu_op, a, b);
        OP_SET:          return word_t'(ref_cmp(ins.ctrl.cmp_op, ins.rs1, cb));
        OP_JAL, OP_JALR: return ins.pc + word_t'(PC_STEP);
        default:         return '0;
    endcase
endfunction

function automatic redirect_t ref_redirect(issue_t ins);
    redirect_t r;
    r.valid  = 1'b0;
    r.target = ins.pc + ins.imm;
    case (ins.ctrl.op_kind)
        OP_BRANCH: r.valid = ref_cmp(ins.ctrl.cmp_op, ins.rs1, ins.rs2);
        OP_JAL:    r.valid = 1'b1;
        OP_JALR: begin
            r.valid  = 1'b1;
            r.target = (ins.rs1 + ins.imm) & ~word_t'(1);
        end
        default:   r.valid = 1'b0;
    endcase
    return r;
endfunction

// Lanes from the offset up, one, two or four bytes wide
function automatic byte_en_t ref_byte_en(mem_size_e size, logic [1:0] off);
    int       width;
    int       lane;
    byte_en_t be;
    case (size)
        MEM_B, MEM_BU: width = 1;
        MEM_H, MEM_HU: width = 2;
        default:       width = BYTE_LANES;
    endcase
    be = '0;
    for (lane = 0; lane < BYTE_LANES; lane++) begin
        be[lane] = (lane >= int'(off)) && (lane < int'(off) + width);
    end
    return be;
endfunction

function automatic word_t ref_store_data(logic [1:0] off, word_t data);
    return data << (8 * off);
endfunction

function automatic word_t ref_load(mem_size_e size, logic [1:0] off, word_t w);
    word_t s;
    s = w >> (8 * off);
    case (size)
        MEM_B:   return {{24{s[7]}}, s[7:0]};
        MEM_BU:  return {24'b0, s[7:0]};
        MEM_H:   return {{16{s[15]}}, s[15:0]};
        MEM_HU:  return {16'b0, s[15:0]};
        default: return w;
    endcase
endfunction

`endif

/* verif/tb_rv32i_exmem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv32i_exmem
    import rv32i_pkg::*;
();

    `include "tb_ref_model.svh"

    localparam int MEM_WORDS  = 64;
    localparam int WAIT_LIMIT = 200;
    localparam int SLOW_DELAY = 6;

    logic      i_clk = 1'b0;
    logic      i_rst_n;
    issue_t    i_issue;
    logic      o_issue_ready;
    redirect_t o_redirect;
    dmem_req_t o_dmem;
    logic      i_dmem_resp = 1'b0;
    word_t     i_dmem_rdata = '0;
    wb_t       o_wb;

    word_t     dmem [MEM_WORDS];
    word_t     model_mem [MEM_WORDS];
    dmem_req_t req_log [$];
    dmem_req_t exp_req [$];
    wb_t       exp_wb [$];
    int        exp_wb_due [$];
    word_t     exp_redir [$];
    int        exp_redir_due [$];

    mem_size_e load_sizes [5]  = '{MEM_B, MEM_BU, MEM_H, MEM_HU, MEM_W};
    mem_size_e store_sizes [3] = '{MEM_B, MEM_H, MEM_W};
    cmp_op_e   legal_cmps [6]  = '{CMP_BEQ, CMP_BNE, CMP_BLT, CMP_BGE, CMP_BLTU, CMP_BGEU};

    int    cycle = 0;
    int    errors = 0;
    int    checks = 0;
    int    tests_run = 0;
    int    issued = 0;
    int    retired = 0;
    int    start_errors = 0;
    int    start_issued = 0;
    int    start_retired = 0;
    logic  slow_mode = 1'b0;
    logic  req_seen = 1'b0;
    logic  resp_prev = 1'b0;
    int    delay_cnt = 0;
    string test_name = "reset";

    rv32i_exmem_core rv32i_exmem_core_inst (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_issue       (i_issue),
        .o_issue_ready (o_issue_ready),
        .o_redirect    (o_redirect),
        .o_dmem        (o_dmem),
        .i_dmem_resp   (i_dmem_resp),
        .i_dmem_rdata  (i_dmem_rdata),
        .o_wb          (o_wb)
    );

    always #4 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycle <= cycle + 1;
    end

    // Response as the DUT saw it at the previous edge
    always @(posedge i_clk) begin
        resp_prev <= i_dmem_resp;
    end

    task automatic check_value(input string what, input logic [127:0] expected,
                               input logic [127:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %s %s expected %h actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic note_error(input string what);
        errors++;
        $display("Error in %s: %s", test_name, what);
    endtask

    task automatic abort_run(input string what);
        $display("Timeout in %s while waiting for %s", test_name, what);
        $display("*** TEST FAILED ***");
        $finish;
    endtask

    function automatic word_t fill_word(int idx);
        return word_t'(idx * 32'h0104_1043) ^ 32'h5A3C_0F1E;
    endfunction

    function automatic logic legal_cmp(logic [2:0] code);
        return (code != 3'b010) && (code != 3'b011);
    endfunction

    function automatic logic misaligned(logic [2:0] size, logic [1:0] off);
        case (size)
            MEM_H, MEM_HU: return off[0];
            MEM_W:         return off != 2'b00;
            default:       return 1'b0;
        endcase
    endfunction

    // Trap on a bad compare code, a bad width or an unaligned half or word
    function automatic logic expect_trap(issue_t ins);
        word_t      addr;
        logic [2:0] size;
        addr = ins.rs1 + ins.imm;
        size = ins.ctrl.mem_size;
        case (ins.ctrl.op_kind)
            OP_BRANCH, OP_SET: return !legal_cmp(ins.ctrl.cmp_op);
            OP_LOAD: return !(size inside {MEM_B, MEM_H, MEM_W, MEM_BU, MEM_HU}) ||
                            misaligned(size, addr[1:0]);
            OP_STORE: return !(size inside {MEM_B, MEM_H, MEM_W}) ||
                             misaligned(size, addr[1:0]);
            default: return 1'b0;
        endcase
    endfunction

    function automatic wb_t expect_wb(issue_t ins);
        wb_t   wb;
        word_t addr;
        addr     = ins.rs1 + ins.imm;
        wb.valid = 1'b1;
        wb.trap  = expect_trap(ins);
        wb.rd    = ins.rd;
        if (wb.trap) begin
            wb.data = '0;
        end else if (ins.ctrl.op_kind == OP_LOAD) begin
            wb.data = ref_load(ins.ctrl.mem_size, addr[1:0], model_mem[addr[7:2]]);
        end else begin
            wb.data = ref_result(ins);
        end
        return wb;
    endfunction

    function automatic dmem_req_t expect_req(issue_t ins);
        dmem_req_t req;
        word_t     addr;
        addr        = ins.rs1 + ins.imm;
        req.read    = ins.ctrl.op_kind == OP_LOAD;
        req.write   = ins.ctrl.op_kind == OP_STORE;
        req.addr    = addr & ~word_t'(3);
        req.wdata   = ref_store_data(addr[1:0], ins.rs2);
        req.byte_en = ref_byte_en(ins.ctrl.mem_size, addr[1:0]);
        return req;
    endfunction

    function automatic issue_t make_ins(op_kind_e kind);
        issue_t ins;
        ins               = '0;
        ins.valid         = 1'b1;
        ins.ctrl.op_kind  = kind;
        ins.ctrl.alu_op   = ALU_ADD;
        ins.ctrl.cmp_op   = CMP_BEQ;
        ins.ctrl.mem_size = MEM_W;
        ins.ctrl.src_a    = SRC_A_RS1;
        ins.ctrl.src_b    = SRC_B_IMM;
        ins.pc            = word_t'($urandom()) & ~word_t'(3);
        ins.rs1           = word_t'($urandom());
        ins.rs2           = word_t'($urandom());
        ins.imm           = word_t'($urandom_range(4095, 0)) - word_t'(2048);
        ins.rd            = reg_idx_t'($urandom_range(31, 1));
        return ins;
    endfunction

    // Base register chosen so rs1 + imm lands on addr
    function automatic issue_t mem_ins(op_kind_e kind, mem_size_e size, word_t addr);
        issue_t ins;
        ins               = make_ins(kind);
        ins.ctrl.mem_size = size;
        ins.imm           = word_t'($urandom_range(31, 0)) - word_t'(16);
        ins.rs1           = addr - ins.imm;
        return ins;
    endfunction

    task automatic issue(input issue_t ins);
        int        waited;
        int        lane;
        wb_t       wb;
        redirect_t redir;
        dmem_req_t req;
        logic      mem_ok;
        ins.valid = 1'b1;
        i_issue <= ins;
        @(posedge i_clk);
        waited = 0;
        while (!o_issue_ready) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("issue ready");
            end
            @(posedge i_clk);
        end
        // Accepted at this edge
        issued++;
        wb     = expect_wb(ins);
        mem_ok = (ins.ctrl.op_kind == OP_LOAD || ins.ctrl.op_kind == OP_STORE) && !wb.trap;
        exp_wb.push_back(wb);
        exp_wb_due.push_back(mem_ok ? -1 : cycle + 2);
        redir = ref_redirect(ins);
        if (redir.valid) begin
            exp_redir.push_back(redir.target);
            exp_redir_due.push_back(cycle + 1);
        end
        if (mem_ok) begin
            req = expect_req(ins);
            exp_req.push_back(req);
            if (req.write) begin
                for (lane = 0; lane < BYTE_LANES; lane++) begin
                    if (req.byte_en[lane]) begin
                        model_mem[req.addr[7:2]][8*lane +: 8] = req.wdata[8*lane +: 8];
                    end
                end
            end
        end
    endtask

    task automatic go_idle();
        i_issue.valid <= 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_wb.size() != 0) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("outstanding writebacks");
            end
            @(posedge i_clk);
        end
        repeat (2) @(posedge i_clk);
        if (exp_redir.size() != 0) begin
            note_error("an expected redirect never appeared");
            exp_redir.delete();
            exp_redir_due.delete();
        end
    endtask

    task automatic match_requests();
        check_value("request count", exp_req.size(), req_log.size());
        while (exp_req.size() != 0 && req_log.size() != 0) begin
            check_value("memory request", exp_req.pop_front(), req_log.pop_front());
        end
        exp_req.delete();
        req_log.delete();
    endtask

    task automatic begin_test(input string name);
        test_name     = name;
        start_errors  = errors;
        start_issued  = issued;
        start_retired = retired;
    endtask

    task automatic end_test();
        int idx;
        drain();
        match_requests();
        for (idx = 0; idx < MEM_WORDS; idx++) begin
            check_value("memory word", model_mem[idx], dmem[idx]);
        end
        check_value("result count", issued - start_issued, retired - start_retired);
        tests_run++;
        if (errors == start_errors) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, errors - start_errors);
        end
    endtask

    // Data memory model with a random response delay
    always @(posedge i_clk) begin : responder
        int lane;
        if (!i_rst_n) begin
            i_dmem_resp <= 1'b0;
            req_seen    <= 1'b0;
        end else if (i_dmem_resp) begin
            i_dmem_resp <= 1'b0;
            req_seen    <= 1'b0;
        end else if (o_dmem.read || o_dmem.write) begin
            if (o_issue_ready) begin
                note_error("issue side ready while a memory access is pending");
            end
            if (!req_seen) begin
                req_seen  <= 1'b1;
                delay_cnt <= slow_mode ? SLOW_DELAY : int'($urandom_range(3, 0));
                req_log.push_back(o_dmem);
            end else if (delay_cnt == 0) begin
                i_dmem_resp <= 1'b1;
                if (o_dmem.read) begin
                    i_dmem_rdata <= dmem[o_dmem.addr[7:2]];
                end else begin
                    for (lane = 0; lane < BYTE_LANES; lane++) begin
                        if (o_dmem.byte_en[lane]) begin
                            dmem[o_dmem.addr[7:2]][8*lane +: 8] = o_dmem.wdata[8*lane +: 8];
                        end
                    end
                end
            end else begin
                delay_cnt <= delay_cnt - 1;
            end
        end
    end

    always @(posedge i_clk) begin : wb_compare
        int due;
        if (i_rst_n && o_wb.valid) begin
            retired++;
            if (exp_wb.size() == 0) begin
                note_error("writeback with no instruction outstanding");
            end else begin
                due = exp_wb_due.pop_front();
                check_value("writeback", exp_wb.pop_front(), o_wb);
                if (due >= 0) begin
                    check_value("writeback cycle", due, cycle);
                end else begin
                    check_value("writeback after response", 1'b1, resp_prev);
                end
            end
        end
    end

    always @(posedge i_clk) begin : redirect_compare
        int due;
        if (i_rst_n && o_redirect.valid) begin
            if (exp_redir.size() == 0) begin
                note_error("redirect raised with none expected");
            end else begin
                due = exp_redir_due.pop_front();
                check_value("redirect target", exp_redir.pop_front(), o_redirect.target);
                check_value("redirect cycle", due, cycle);
            end
        end
    end

    initial begin : stimulus
        int        n;
        int        pick;
        int        s;
        int        off;
        int        k;
        issue_t    ins;
        mem_size_e size;
        word_t     addr;
        void'($urandom(73));
        i_rst_n = 1'b0;
        i_issue = '0;
        for (n = 0; n < MEM_WORDS; n++) begin
            dmem[n]      = fill_word(n);
            model_mem[n] = fill_word(n);
        end
        repeat (3) @(posedge i_clk);
        i_rst_n <= 1'b1;
        @(posedge i_clk);

        begin_test("reset");
        check_value("issue ready", 1'b1, o_issue_ready);
        check_value("wb valid", 1'b0, o_wb.valid);
        check_value("redirect valid", 1'b0, o_redirect.valid);
        check_value("dmem read", 1'b0, o_dmem.read);
        check_value("dmem write", 1'b0, o_dmem.write);
        end_test();

        begin_test("alu_set_lui");
        for (n = 0; n < 48; n++) begin
            pick = $urandom_range(5, 0);
            if (pick < 4) begin
                ins               = make_ins(OP_ALU);
                ins.ctrl.alu_op   = alu_op_e'($urandom_range(7, 0));
                ins.ctrl.src_a    = src_a_e'($urandom_range(1, 0));
                ins.ctrl.src_b    = src_b_e'($urandom_range(1, 0));
            end else if (pick == 4) begin
                ins               = make_ins(OP_SET);
                ins.ctrl.cmp_op   = ($urandom_range(1, 0) != 0) ? CMP_BLTU : CMP_BLT;
                ins.ctrl.src_b    = src_b_e'($urandom_range(1, 0));
            end else begin
                ins               = make_ins(OP_LUI);
                ins.rs1           = '0;
                ins.imm           = word_t'($urandom()) & 32'hFFFF_F000;
            end
            issue(ins);
        end
        go_idle();
        end_test();

        begin_test("branch_jump");
        for (n = 0; n < 36; n++) begin
            pick = $urandom_range(3, 0);
            if (pick < 2) begin
                ins             = make_ins(OP_BRANCH);
                ins.ctrl.cmp_op = legal_cmps[$urandom_range(5, 0)];
                ins.ctrl.src_a  = SRC_A_PC;
                if ($urandom_range(2, 0) == 0) begin
                    ins.rs2 = ins.rs1;
                end
            end else if (pick == 2) begin
                ins            = make_ins(OP_JAL);
                ins.ctrl.src_a = SRC_A_PC;
            end else begin
                ins     = make_ins(OP_JALR);
                // Odd base so the target needs bit 0 cleared
                ins.rs1 = ins.rs1 | word_t'(1);
            end
            ins.imm[0] = 1'b0;
            issue(ins);
        end
        go_idle();
        end_test();

        begin_test("store");
        for (n = 0; n < 24; n++) begin
            size = store_sizes[$urandom_range(2, 0)];
            addr = word_t'($urandom_range(255, 0));
            if (size == MEM_H) begin
                addr[0] = 1'b0;
            end else if (size == MEM_W) begin
                addr[1:0] = 2'b00;
            end
            issue(mem_ins(OP_STORE, size, addr));
        end
        go_idle();
        end_test();

        begin_test("load");
        for (s = 0; s < 5; s++) begin
            for (off = 0; off < 4; off++) begin
                if (!misaligned(load_sizes[s], off[1:0])) begin
                    for (k = 0; k < 3; k++) begin
                        addr = word_t'(($urandom_range(63, 0) << 2) | off);
                        issue(mem_ins(OP_LOAD, load_sizes[s], addr));
                    end
                end
            end
        end
        go_idle();
        end_test();

        begin_test("trap");
        issue(mem_ins(OP_LOAD, MEM_H, word_t'(32'h41)));
        issue(mem_ins(OP_LOAD, MEM_HU, word_t'(32'h43)));
        issue(mem_ins(OP_LOAD, MEM_W, word_t'(32'h52)));
        issue(mem_ins(OP_LOAD, MEM_W, word_t'(32'h63)));
        issue(mem_ins(OP_STORE, MEM_H, word_t'(32'h71)));
        issue(mem_ins(OP_STORE, MEM_W, word_t'(32'h82)));
        issue(mem_ins(OP_STORE, MEM_BU, word_t'(32'h84)));
        issue(mem_ins(OP_LOAD, mem_size_e'(3'b011), word_t'(32'h90)));
        ins             = make_ins(OP_BRANCH);
        ins.ctrl.cmp_op = cmp_op_e'(3'b010);
        ins.ctrl.src_a  = SRC_A_PC;
        ins.rs2         = ins.rs1;
        issue(ins);
        ins             = make_ins(OP_SET);
        ins.ctrl.cmp_op = cmp_op_e'(3'b011);
        issue(ins);
        go_idle();
        end_test();

        begin_test("back_pressure");
        slow_mode = 1'b1;
        for (n = 0; n < 4; n++) begin
            issue(mem_ins(OP_LOAD, MEM_W, word_t'(n * 4 + 32)));
            ins             = make_ins(OP_ALU);
            ins.ctrl.alu_op = ALU_XOR;
            ins.ctrl.src_b  = SRC_B_RS2;
            issue(ins);
        end
        go_idle();
        end_test();
        slow_mode = 1'b0;

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+include
source/rv32i_pkg.sv
source/exec_alu.sv
source/branch_cmp.sv
source/ex_stage.sv
source/mem_stage.sv
source/rv32i_exmem_core.sv
verif/tb_rv32i_exmem.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_rv32i_exmem
LINT_TOP   ?= rv32i_exmem_core
FILELIST   ?= list.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= -Wall
PASS_TEXT  ?= *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(BUILD_DIR)
